// ==== riscv_hzrd_pkg.sv ====
package riscv_hzrd_pkg;

  // widths with a meaning of their own
  typedef logic [4:0] regaddr_t;   // x0..x31
  typedef logic [6:0] opcode_t;    // major opcode, instr[6:0]
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [1:0] resultsrc_t; // writeback source select
  typedef logic [1:0] fwdsel_t;    // execute operand forward select

  // major opcodes used by the hazard logic
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam resultsrc_t RES_ALU  = 2'd0;
  localparam resultsrc_t RES_LOAD = 2'd2; // data comes back from the dcache

  localparam funct7_t FUNCT7_MULDIV = 7'd1; // M extension on OP

  // operand forward select encodings
  localparam fwdsel_t FWD_REGF    = 2'd0;
  localparam fwdsel_t FWD_WB      = 2'd1;
  localparam fwdsel_t FWD_MEM_ALU = 2'd2;
  localparam fwdsel_t FWD_MEM_LUI = 2'd3; // upper immediate of a LUI in memory

  // register usage of one instruction as it moves down the pipe
  typedef struct packed {
    regaddr_t   rs1;
    regaddr_t   rs2;
    regaddr_t   rd;        // zero when the instruction writes nothing
    opcode_t    opcode;
    logic       regw;
    resultsrc_t resultsrc;
    logic       iscsr;
    logic       muldiv;    // multiply or divide, waits for the result-valid level
  } stage_tag_t;

  // all zero tag, no reads that matter and no writes
  localparam stage_tag_t TAG_BUBBLE = '0;

endpackage

// ==== riscv_decode_tags.sv ====
`timescale 1ns/10ps

module riscv_decode_tags
  import riscv_hzrd_pkg::*;
(
  input  logic [31:0] i_riscv_instr,
  output stage_tag_t  o_riscv_tag
);

  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  regaddr_t rd_field;
  logic     writes_rd;

  assign opcode   = i_riscv_instr[6:0];
  assign funct3   = i_riscv_instr[14:12];
  assign funct7   = i_riscv_instr[31:25];
  assign rd_field = i_riscv_instr[11:7];

  // which major opcodes write back to the register file
  always_comb
  begin
    case (opcode)
      OPC_LUI,
      OPC_OP,
      OPC_OPIMM,
      OPC_LOAD,
      OPC_SYSTEM:
      begin
        writes_rd = 1'b1;
      end
      OPC_STORE,
      OPC_BRANCH:
      begin
        writes_rd = 1'b0; // bits 11:7 hold immediate bits here
      end
      default:
      begin
        writes_rd = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    o_riscv_tag.rs1    = i_riscv_instr[19:15];
    o_riscv_tag.rs2    = i_riscv_instr[24:20];
    o_riscv_tag.opcode = opcode;
    o_riscv_tag.regw   = writes_rd;

    // no destination means nothing downstream can match it
    if (writes_rd)
    begin
      o_riscv_tag.rd = rd_field;
    end
    else
    begin
      o_riscv_tag.rd = '0;
    end

    o_riscv_tag.resultsrc = (opcode == OPC_LOAD) ? RES_LOAD : RES_ALU;

    // ecall/ebreak/mret have funct3 0, only csrrw..csrrci count
    o_riscv_tag.iscsr  = (opcode == OPC_SYSTEM) && (funct3 != 3'd0);
    o_riscv_tag.muldiv = (opcode == OPC_OP) && (funct7 == FUNCT7_MULDIV);
  end

endmodule

// ==== riscv_stage_regs.sv ====
`timescale 1ns/10ps

module riscv_stage_regs
  import riscv_hzrd_pkg::*;
(
  input  logic       i_riscv_clk,
  input  logic       i_arst_n,
  input  stage_tag_t i_riscv_fetch_tag,
  input  logic       i_riscv_stallfd,
  input  logic       i_riscv_stallde,
  input  logic       i_riscv_stallem,
  input  logic       i_riscv_stallmw,
  input  logic       i_riscv_flushfd,
  input  logic       i_riscv_flushde,
  output stage_tag_t o_riscv_tag_d,
  output stage_tag_t o_riscv_tag_e,
  output stage_tag_t o_riscv_tag_m,
  output stage_tag_t o_riscv_tag_w
);

  // fetch -> decode, stall wins over flush
  always_ff @(posedge i_riscv_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_riscv_tag_d <= TAG_BUBBLE;
    end
    else if (!i_riscv_stallfd)
    begin
      if (i_riscv_flushfd)
      begin
        o_riscv_tag_d <= TAG_BUBBLE; // redirect kills the fetched instruction
      end
      else
      begin
        o_riscv_tag_d <= i_riscv_fetch_tag;
      end
    end
  end

  // decode -> execute
  always_ff @(posedge i_riscv_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_riscv_tag_e <= TAG_BUBBLE;
    end
    else if (!i_riscv_stallde)
    begin
      if (i_riscv_flushde)
      begin
        o_riscv_tag_e <= TAG_BUBBLE; // load-use bubble or redirect
      end
      else
      begin
        o_riscv_tag_e <= o_riscv_tag_d;
      end
    end
  end

  // execute -> memory, keeps moving while a bubble goes into execute
  always_ff @(posedge i_riscv_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_riscv_tag_m <= TAG_BUBBLE;
    end
    else if (!i_riscv_stallem)
    begin
      o_riscv_tag_m <= o_riscv_tag_e;
    end
  end

  // memory -> writeback
  always_ff @(posedge i_riscv_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_riscv_tag_w <= TAG_BUBBLE;
    end
    else if (!i_riscv_stallmw)
    begin
      o_riscv_tag_w <= o_riscv_tag_m;
    end
  end

endmodule

// ==== riscv_hazardunit.sv ====
`timescale 1ns/10ps

module riscv_hazardunit
  import riscv_hzrd_pkg::*;
(
  input  stage_tag_t i_riscv_tag_d,
  input  stage_tag_t i_riscv_tag_e,
  input  stage_tag_t i_riscv_tag_m,
  input  stage_tag_t i_riscv_tag_w,
  input  logic       i_riscv_pcsrc,
  input  logic       i_riscv_dcache_stall,
  input  logic       i_riscv_icache_stall,
  input  logic       i_riscv_muldiv_valid,
  output fwdsel_t    o_riscv_fwda,
  output fwdsel_t    o_riscv_fwdb,
  output logic       o_riscv_stallpc,
  output logic       o_riscv_stallfd,
  output logic       o_riscv_stallde,
  output logic       o_riscv_stallem,
  output logic       o_riscv_stallmw,
  output logic       o_riscv_flushfd,
  output logic       o_riscv_flushde,
  output logic       o_riscv_globstall,
  output logic       o_riscv_passwb
);

  logic m_stall;      // multiply/divide still busy in execute
  logic glob_stall;
  logic rs1_hit_e;    // decode rs1 produced by execute
  logic rs2_hit_e;
  logic e_late;       // execute result not ready for a dependent in decode
  logic ld_csr_stall;
  logic ld_csr_flush;

  // forward select for one execute source, memory stage has priority
  function automatic fwdsel_t fwd_sel(
    input regaddr_t   rs,
    input stage_tag_t tag_m,
    input stage_tag_t tag_w
  );
    logic hit_m;
    logic hit_w;
    hit_m = (rs == tag_m.rd) && tag_m.regw && (tag_m.rd != '0);
    hit_w = (rs == tag_w.rd) && tag_w.regw && (tag_w.rd != '0);
    if (hit_m && (tag_m.opcode == OPC_LUI))
    begin
      fwd_sel = FWD_MEM_LUI;
    end
    else if (hit_m)
    begin
      fwd_sel = FWD_MEM_ALU;
    end
    else if (hit_w)
    begin
      fwd_sel = FWD_WB;
    end
    else
    begin
      fwd_sel = FWD_REGF;
    end
  endfunction

  assign o_riscv_fwda = fwd_sel(i_riscv_tag_e.rs1, i_riscv_tag_m, i_riscv_tag_w);
  assign o_riscv_fwdb = fwd_sel(i_riscv_tag_e.rs2, i_riscv_tag_m, i_riscv_tag_w);

  // caches or an unfinished multiply freeze the whole pipe
  assign m_stall    = i_riscv_tag_e.muldiv & ~i_riscv_muldiv_valid;
  assign glob_stall = i_riscv_dcache_stall | i_riscv_icache_stall | m_stall;

  assign o_riscv_globstall = glob_stall;

  assign rs1_hit_e = (i_riscv_tag_d.rs1 == i_riscv_tag_e.rd);
  assign rs2_hit_e = (i_riscv_tag_d.rs2 == i_riscv_tag_e.rd);

  // load data, or a csr read value seen by a non-csr reader
  assign e_late = (i_riscv_tag_e.resultsrc == RES_LOAD) ||
                  (i_riscv_tag_e.iscsr && !i_riscv_tag_d.iscsr);

  // a csr in decode has its csr address in the rs2 field, so skip that compare
  assign ld_csr_stall = (rs1_hit_e || (rs2_hit_e && !i_riscv_tag_d.iscsr)) && e_late;
  assign ld_csr_flush = (rs1_hit_e || rs2_hit_e) && e_late;

  always_comb
  begin
    o_riscv_stallpc = ld_csr_stall | glob_stall;
    o_riscv_stallfd = ld_csr_stall | glob_stall;
    o_riscv_stallde = glob_stall;
    o_riscv_stallem = glob_stall;
    o_riscv_stallmw = glob_stall;
  end

  // nothing is flushed while the pipe is frozen
  assign o_riscv_flushde = (ld_csr_flush | i_riscv_pcsrc) & ~glob_stall;
  assign o_riscv_flushfd = i_riscv_pcsrc & ~glob_stall;

  // back to back csr ops, memory reads the csr value still in writeback
  assign o_riscv_passwb = i_riscv_tag_m.iscsr && i_riscv_tag_w.iscsr &&
                          (i_riscv_tag_w.rd == i_riscv_tag_m.rs1);

endmodule

// ==== riscv_hzrd_top.sv ====
`timescale 1ns/10ps

module riscv_hzrd_top
  import riscv_hzrd_pkg::*;
(
  input  logic        i_riscv_clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_riscv_instr,
  input  logic        i_riscv_pcsrc,
  input  logic        i_riscv_dcache_stall,
  input  logic        i_riscv_icache_stall,
  input  logic        i_riscv_muldiv_valid,
  output fwdsel_t     o_riscv_fwda,
  output fwdsel_t     o_riscv_fwdb,
  output logic        o_riscv_stallpc,
  output logic        o_riscv_stallfd,
  output logic        o_riscv_stallde,
  output logic        o_riscv_stallem,
  output logic        o_riscv_stallmw,
  output logic        o_riscv_flushfd,
  output logic        o_riscv_flushde,
  output logic        o_riscv_globstall,
  output logic        o_riscv_passwb
);

  stage_tag_t fetch_tag;
  stage_tag_t tag_d;
  stage_tag_t tag_e;
  stage_tag_t tag_m;
  stage_tag_t tag_w;

  riscv_decode_tags u_decode_tags (
    .i_riscv_instr (i_riscv_instr),
    .o_riscv_tag   (fetch_tag)
  );

  // stall and flush strobes loop back from the hazard unit
  riscv_stage_regs u_stage_regs (
    .i_riscv_clk       (i_riscv_clk),
    .i_arst_n          (i_arst_n),
    .i_riscv_fetch_tag (fetch_tag),
    .i_riscv_stallfd   (o_riscv_stallfd),
    .i_riscv_stallde   (o_riscv_stallde),
    .i_riscv_stallem   (o_riscv_stallem),
    .i_riscv_stallmw   (o_riscv_stallmw),
    .i_riscv_flushfd   (o_riscv_flushfd),
    .i_riscv_flushde   (o_riscv_flushde),
    .o_riscv_tag_d     (tag_d),
    .o_riscv_tag_e     (tag_e),
    .o_riscv_tag_m     (tag_m),
    .o_riscv_tag_w     (tag_w)
  );

  riscv_hazardunit u_hazardunit (
    .i_riscv_tag_d        (tag_d),
    .i_riscv_tag_e        (tag_e),
    .i_riscv_tag_m        (tag_m),
    .i_riscv_tag_w        (tag_w),
    .i_riscv_pcsrc        (i_riscv_pcsrc),
    .i_riscv_dcache_stall (i_riscv_dcache_stall),
    .i_riscv_icache_stall (i_riscv_icache_stall),
    .i_riscv_muldiv_valid (i_riscv_muldiv_valid),
    .o_riscv_fwda         (o_riscv_fwda),
    .o_riscv_fwdb         (o_riscv_fwdb),
    .o_riscv_stallpc      (o_riscv_stallpc),
    .o_riscv_stallfd      (o_riscv_stallfd),
    .o_riscv_stallde      (o_riscv_stallde),
    .o_riscv_stallem      (o_riscv_stallem),
    .o_riscv_stallmw      (o_riscv_stallmw),
    .o_riscv_flushfd      (o_riscv_flushfd),
    .o_riscv_flushde      (o_riscv_flushde),
    .o_riscv_globstall    (o_riscv_globstall),
    .o_riscv_passwb       (o_riscv_passwb)
  );

endmodule

// ==== riscv_hzrd_tb.sv ====
`timescale 1ns/10ps

module riscv_hzrd_tb
  import riscv_hzrd_pkg::*;
();

  localparam int NUM_CASES = 42;
  localparam int RESET_TIMEOUT = 20; // cycles

  logic        clk;
  logic        arst_n;
  logic [31:0] instr;
  logic        pcsrc;
  logic        dcache_stall;
  logic        icache_stall;
  logic        muldiv_valid;
  fwdsel_t     fwda;
  fwdsel_t     fwdb;
  logic        stallpc;
  logic        stallfd;
  logic        stallde;
  logic        stallem;
  logic        stallmw;
  logic        flushfd;
  logic        flushde;
  logic        globstall;
  logic        passwb;

  riscv_hzrd_top dut (
    .i_riscv_clk          (clk),
    .i_arst_n             (arst_n),
    .i_riscv_instr        (instr),
    .i_riscv_pcsrc        (pcsrc),
    .i_riscv_dcache_stall (dcache_stall),
    .i_riscv_icache_stall (icache_stall),
    .i_riscv_muldiv_valid (muldiv_valid),
    .o_riscv_fwda         (fwda),
    .o_riscv_fwdb         (fwdb),
    .o_riscv_stallpc      (stallpc),
    .o_riscv_stallfd      (stallfd),
    .o_riscv_stallde      (stallde),
    .o_riscv_stallem      (stallem),
    .o_riscv_stallmw      (stallmw),
    .o_riscv_flushfd      (flushfd),
    .o_riscv_flushde      (flushde),
    .o_riscv_globstall    (globstall),
    .o_riscv_passwb       (passwb)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    string msg;
    if (expected !== actual)
    begin
      msg = $sformatf("ERROR: time %0t signal %s expected %0h actual %0h",
                      $time, name, expected, actual);
      abort_run(msg);
    end
  endtask

  // reset held low for 4 cycles
  initial
  begin
    arst_n = 1'b0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
  end

  // overall limit on the run
  initial
  begin
    #20000;
    abort_run("simulation did not finish in time");
  end

  initial
  begin
    int fd;
    int r;
    int n;
    int cyc;
    int ncases;
    logic [8*160-1:0] line;
    logic [31:0] f_instr;
    logic [31:0] f_pcsrc;
    logic [31:0] f_dc;
    logic [31:0] f_ic;
    logic [31:0] f_mv;
    logic [31:0] e_fwda;
    logic [31:0] e_fwdb;
    logic [31:0] e_grp;   // stallpc stallfd stallde stallem stallmw flushfd flushde
    logic [31:0] e_glob;
    logic [31:0] e_pass;

    instr        = 32'h0000_0013;
    pcsrc        = 1'b0;
    dcache_stall = 1'b0;
    icache_stall = 1'b0;
    muldiv_valid = 1'b0;
    ncases       = 0;

    fd = $fopen("hzrd_cases.txt", "r");
    if (fd == 0)
    begin
      abort_run("cannot open the cases file hzrd_cases.txt");
    end

    cyc = 0;
    while (arst_n !== 1'b1 && cyc < RESET_TIMEOUT)
    begin
      @(posedge clk);
      cyc++;
    end
    if (arst_n !== 1'b1)
    begin
      abort_run("reset was never released");
    end

    while (ncases < NUM_CASES)
    begin
      line = '0;
      r = $fgets(line, fd);
      if (r == 0)
      begin
        abort_run("the cases file ends before all cases were read");
      end
      n = $sscanf(line, "%h %b %b %b %b %d %d %b %b %b", f_instr, f_pcsrc, f_dc, f_ic,
                  f_mv, e_fwda, e_fwdb, e_grp, e_glob, e_pass);
      if (n > 0 && n != 10)
      begin
        abort_run("a line of the cases file has the wrong number of fields");
      end
      else if (n == 10)
      begin
        @(negedge clk);
        instr        = f_instr;
        pcsrc        = f_pcsrc[0];
        dcache_stall = f_dc[0];
        icache_stall = f_ic[0];
        muldiv_valid = f_mv[0];
        #1;
        check_value("fwda", e_fwda, 32'(fwda));
        check_value("fwdb", e_fwdb, 32'(fwdb));
        check_value("stallpc", 32'(e_grp[6]), 32'(stallpc));
        check_value("stallfd", 32'(e_grp[5]), 32'(stallfd));
        check_value("stallde", 32'(e_grp[4]), 32'(stallde));
        check_value("stallem", 32'(e_grp[3]), 32'(stallem));
        check_value("stallmw", 32'(e_grp[2]), 32'(stallmw));
        check_value("flushfd", 32'(e_grp[1]), 32'(flushfd));
        check_value("flushde", 32'(e_grp[0]), 32'(flushde));
        check_value("globstall", e_glob, 32'(globstall));
        check_value("passwb", e_pass, 32'(passwb));
        ncases++;
      end
    end

    $fclose(fd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== hzrd_cases.txt ====
# instr pcsrc dcache_stall icache_stall muldiv_valid | expected fwda fwdb
# stall/flush bits (stallpc stallfd stallde stallem stallmw flushfd flushde) globstall passwb
00000013 0 0 0 0 0 0 0000000 0 0
00000093 0 0 0 0 0 0 0000000 0 0
00000113 0 0 0 0 0 0 0000000 0 0
002081B3 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 1 2 0000000 0 0
120003B7 0 0 0 0 0 0 0000000 0 0
00738433 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00840033 0 0 0 0 3 3 0000000 0 0
000004B3 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 1 1 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
0000A203 0 0 0 0 0 0 0000000 0 0
002202B3 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 1100001 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 1 0 0000000 0 0
00000313 0 0 0 0 0 0 0000000 0 0
00000513 1 0 0 0 0 0 0000011 0 0
00A305B3 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 1 1 0 0 0 0 1111100 1 0
00000013 0 0 1 0 0 0 1111100 1 0
00000013 0 0 0 0 0 0 0000000 0 0
02208633 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 1111100 1 0
00000013 0 0 0 1 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
300016F3 0 0 0 0 0 0 0000000 0 0
00068733 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 1100001 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 1 0 0000000 0 0
300017F3 0 0 0 0 0 0 0000000 0 0
30079873 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 0
00000013 0 0 0 0 2 0 0000000 0 0
00000013 0 0 0 0 0 0 0000000 0 1
00000013 0 0 0 0 0 0 0000000 0 0

// ==== vlog.f ====
riscv_hzrd_pkg.sv
riscv_decode_tags.sv
riscv_stage_regs.sv
riscv_hazardunit.sv
riscv_hzrd_top.sv
riscv_hzrd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the hazard-control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f vlog.f --top-module riscv_hzrd_tb -o sim_hzrd
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_hzrd)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi
